//--- hdl/fifo_geom_pkg.sv
// Geometry of the tagged FIFO: word width, depth and pointer sizes
// Referenced by scoped name from the RTL and the testbench
package fifo_geom_pkg;

  // User data word
  localparam int data_width = 32;

  // Number of storage slots
  localparam int depth = 16;

  // Slot index, then the same index with the lap bit on top
  localparam int addr_width = $clog2(depth);
  localparam int ptr_width = addr_width + 1;

  // Occupancy count, wide enough to hold depth itself
  localparam int count_width = ptr_width;

endpackage

//--- hdl/fifo_occupancy.sv
// Occupancy tracker of the tagged FIFO: count, full and empty
// Count is the lap-extended pointer difference, registered
`timescale 1ns/1ps

module fifo_occupancy (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [fifo_geom_pkg::ptr_width-1:0]   wr_ptr_full,
  input  logic [fifo_geom_pkg::ptr_width-1:0]   rd_ptr_full,
  output logic [fifo_geom_pkg::count_width-1:0] count,
  output logic                                  full,
  output logic                                  empty
);

  logic [fifo_geom_pkg::count_width-1:0] ptr_diff;

  // Wraps modulo 2**ptr_width, so overrun and underrun show as odd counts
  assign ptr_diff = wr_ptr_full - rd_ptr_full;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      count <= ptr_diff;
    end
  end

  assign full  = count == fifo_geom_pkg::depth;
  assign empty = count == '0;

  // One strobe per side cannot jump from full straight to empty
  assert property (@(posedge clk) disable iff (reset)
    full |=> !empty);

endmodule

//--- hdl/fifo_read_port.sv
// Read side of the tagged FIFO: read pointer, dout pass/hold path and stale check
// dout follows the memory during a read and holds the last read value otherwise
`timescale 1ns/1ps

module fifo_read_port (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 rd_en,
  input  logic [fifo_word_pkg::mem_width-1:0]  rd_data,
  input  logic                                 rd_slot_valid,
  output logic [fifo_geom_pkg::ptr_width-1:0]  rd_ptr_full,
  output logic [fifo_geom_pkg::ptr_width-1:0]  next_rd_ptr,
  output logic [fifo_geom_pkg::data_width-1:0] dout,
  output logic                                 rd_stale
);

  logic [fifo_geom_pkg::data_width-1:0] rd_word_data;
  logic [fifo_geom_pkg::data_width-1:0] dout_hold;
  logic                                 lap_mismatch;

  // Data field sits in the high bits of the stored word
  assign rd_word_data = rd_data[fifo_word_pkg::data_lsb +: fifo_geom_pkg::data_width];

  always_comb begin
    next_rd_ptr = rd_ptr_full;
    if (rd_en) begin
      next_rd_ptr = rd_ptr_full + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr_full <= '0;
    end else begin
      rd_ptr_full <= next_rd_ptr;
    end
  end

  // Captures each read so dout can hold it while idle
  always_ff @(posedge clk) begin
    if (reset) begin
      dout_hold <= '0;
    end else if (rd_en) begin
      dout_hold <= rd_word_data;
    end
  end

  assign dout = rd_en ? rd_word_data : dout_hold;

  // Stored lap differs when the slot is from an earlier lap or was overrun
  assign lap_mismatch =
    rd_data[fifo_word_pkg::lap_pos] != rd_ptr_full[fifo_geom_pkg::addr_width];

  assign rd_stale = rd_en && (!rd_slot_valid || lap_mismatch);

endmodule

//--- hdl/fifo_store.sv
// Storage array of the tagged FIFO with a valid bit per slot
// Written at the slot field of the incoming word, read combinationally by slot
`timescale 1ns/1ps

module fifo_store (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 mem_we,
  input  logic [fifo_word_pkg::mem_width-1:0]  mem_wdata,
  input  logic [fifo_geom_pkg::addr_width-1:0] rd_slot,
  output logic [fifo_word_pkg::mem_width-1:0]  rd_data,
  output logic                                 rd_slot_valid
);

  logic [fifo_word_pkg::mem_width-1:0]  mem [fifo_geom_pkg::depth];
  logic [fifo_geom_pkg::depth-1:0]      slot_valid;
  logic [fifo_geom_pkg::addr_width-1:0] wr_slot;

  // Target slot travels inside the word itself
  assign wr_slot = mem_wdata[fifo_word_pkg::tag_lsb +: fifo_geom_pkg::addr_width];

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[wr_slot] <= mem_wdata;
    end
  end

  // Marks slots that hold something since reset
  always_ff @(posedge clk) begin
    if (reset) begin
      slot_valid <= '0;
    end else if (mem_we) begin
      slot_valid[wr_slot] <= 1'b1;
    end
  end

  // Same-cycle write and read to one slot returns the old word
  assign rd_data       = mem[rd_slot];
  assign rd_slot_valid = slot_valid[rd_slot];

  // A written slot always carries its own index in the tag field
  assert property (@(posedge clk) disable iff (reset)
    rd_slot_valid |->
      rd_data[fifo_word_pkg::tag_lsb +: fifo_geom_pkg::addr_width] == rd_slot);

endmodule

//--- hdl/fifo_store_chk.sv
// Self-checking monitor for the tagged FIFO: shadow scoreboard, pointer and dout rules
// Instantiated inside the top level, it only observes
`timescale 1ns/1ps

module fifo_store_chk (
  input logic                                 clk,
  input logic                                 wr_en,
  input logic                                 rd_en,
  input logic [fifo_geom_pkg::data_width-1:0] din,
  input logic [fifo_geom_pkg::data_width-1:0] dout,
  input logic [fifo_geom_pkg::ptr_width-1:0]  wr_ptr,
  input logic [fifo_geom_pkg::ptr_width-1:0]  rd_ptr,
  input logic [fifo_geom_pkg::ptr_width-1:0]  next_wr_ptr,
  input logic [fifo_geom_pkg::ptr_width-1:0]  next_rd_ptr,
  input logic [fifo_word_pkg::mem_width-1:0]  rd_data
);

  default clocking cb @(posedge clk);
  endclocking

  logic [fifo_geom_pkg::addr_width-1:0] wr_slot;
  logic [fifo_geom_pkg::addr_width-1:0] rd_slot;
  logic [fifo_geom_pkg::data_width-1:0] model_data [fifo_geom_pkg::depth];
  bit                                   model_vld  [fifo_geom_pkg::depth];

  assign wr_slot = wr_ptr[fifo_geom_pkg::addr_width-1:0];
  assign rd_slot = rd_ptr[fifo_geom_pkg::addr_width-1:0];

  // Shadow copy of the last word written to each slot
  always_ff @(posedge clk) begin
    if (wr_en) begin
      model_data[wr_slot] <= din;
      model_vld[wr_slot]  <= 1'b1;
    end
  end

  // Next-pointer rules
  assert property (wr_en |-> next_wr_ptr == wr_ptr + 1'b1);
  assert property (!wr_en |-> next_wr_ptr == wr_ptr);
  assert property (rd_en |-> next_rd_ptr == rd_ptr + 1'b1);
  assert property (!rd_en |-> next_rd_ptr == rd_ptr);

  // Each pointer takes last cycle's next value
  assert property (!$isunknown($past(next_wr_ptr)) |-> wr_ptr == $past(next_wr_ptr));
  assert property (!$isunknown($past(next_rd_ptr)) |-> rd_ptr == $past(next_rd_ptr));

  // Read data comes from the high field, catches slicing mistakes
  assert property (rd_en |->
    dout == rd_data[fifo_word_pkg::mem_width-1:fifo_word_pkg::data_lsb]);

  // Idle cycles keep showing whatever dout showed last
  assert property (!rd_en && !$isunknown($past(dout)) |-> dout == $past(dout));

  // Slot already written, so the read must return the shadow word
  assert property (rd_en && model_vld[rd_slot] |-> dout == model_data[rd_slot]);

  // Simultaneous read and write
  cover property (wr_en && rd_en);

  // Read of the slot written one cycle earlier
  cover property (wr_en ##1 (rd_en && (rd_ptr == $past(wr_ptr))));

  // Wrap of each pointer from the last slot to slot zero
  cover property ((wr_en && (wr_slot == fifo_geom_pkg::depth - 1))
    ##1 (wr_en && (wr_slot == 0)));
  cover property ((rd_en && (rd_slot == fifo_geom_pkg::depth - 1))
    ##1 (rd_en && (rd_slot == 0)));

endmodule

//--- hdl/fifo_word_pkg.sv
// Bit layout of a stored memory word: slot tag, lap bit, data on top
// Shared by the write port, the store, the read port and the checker
package fifo_word_pkg;

  // Slot index sits in the low bits
  localparam int tag_lsb = 0;

  // Lap bit right above the slot index
  localparam int lap_pos = tag_lsb + fifo_geom_pkg::addr_width;

  // Data occupies the high bits
  localparam int data_lsb = lap_pos + 1;

  // Whole memory word
  localparam int mem_width = fifo_geom_pkg::data_width + fifo_geom_pkg::ptr_width;

endpackage

//--- hdl/fifo_write_port.sv
// Write side of the tagged FIFO: lap-extended write pointer and word assembly
// Advances on every wr_en, with no full check
`timescale 1ns/1ps

module fifo_write_port (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 wr_en,
  input  logic [fifo_geom_pkg::data_width-1:0] din,
  output logic [fifo_geom_pkg::ptr_width-1:0]  wr_ptr_full,
  output logic [fifo_geom_pkg::ptr_width-1:0]  next_wr_ptr,
  output logic                                 mem_we,
  output logic [fifo_word_pkg::mem_width-1:0]  mem_wdata
);

  // Plus one per write, the top bit flips at every wrap
  always_comb begin
    next_wr_ptr = wr_ptr_full;
    if (wr_en) begin
      next_wr_ptr = wr_ptr_full + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_full <= '0;
    end else begin
      wr_ptr_full <= next_wr_ptr;
    end
  end

  // Tag each word with its slot and the current lap
  always_comb begin
    mem_wdata[fifo_word_pkg::data_lsb +: fifo_geom_pkg::data_width] = din;
    mem_wdata[fifo_word_pkg::lap_pos] = wr_ptr_full[fifo_geom_pkg::addr_width];
    mem_wdata[fifo_word_pkg::tag_lsb +: fifo_geom_pkg::addr_width] =
      wr_ptr_full[fifo_geom_pkg::addr_width-1:0];
  end

  assign mem_we = wr_en;

  // Exactly one step per write, also across the wrap of a lap
  assert property (@(posedge clk) disable iff (reset)
    wr_en |=> wr_ptr_full == $past(wr_ptr_full) + 1'b1);

endmodule

//--- hdl/tagged_fifo.sv
// Top level of the tagged FIFO: write port, store, read port, occupancy and checker
// Strobes are not guarded, overrun and underrun are flagged instead of blocked
`timescale 1ns/1ps

module tagged_fifo (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  wr_en,
  input  logic [fifo_geom_pkg::data_width-1:0]  din,
  input  logic                                  rd_en,
  output logic [fifo_geom_pkg::data_width-1:0]  dout,
  output logic                                  rd_stale,
  output logic [fifo_geom_pkg::count_width-1:0] count,
  output logic                                  full,
  output logic                                  empty
);

  logic [fifo_geom_pkg::ptr_width-1:0] wr_ptr_full;
  logic [fifo_geom_pkg::ptr_width-1:0] next_wr_ptr;
  logic [fifo_geom_pkg::ptr_width-1:0] rd_ptr_full;
  logic [fifo_geom_pkg::ptr_width-1:0] next_rd_ptr;
  logic                                mem_we;
  logic [fifo_word_pkg::mem_width-1:0] mem_wdata;
  logic [fifo_word_pkg::mem_width-1:0] rd_data;
  logic                                rd_slot_valid;

  fifo_write_port write_port_i (
    .clk        (clk),
    .reset      (reset),
    .wr_en      (wr_en),
    .din        (din),
    .wr_ptr_full(wr_ptr_full),
    .next_wr_ptr(next_wr_ptr),
    .mem_we     (mem_we),
    .mem_wdata  (mem_wdata)
  );

  fifo_store store_i (
    .clk          (clk),
    .reset        (reset),
    .mem_we       (mem_we),
    .mem_wdata    (mem_wdata),
    .rd_slot      (rd_ptr_full[fifo_geom_pkg::addr_width-1:0]),
    .rd_data      (rd_data),
    .rd_slot_valid(rd_slot_valid)
  );

  fifo_read_port read_port_i (
    .clk          (clk),
    .reset        (reset),
    .rd_en        (rd_en),
    .rd_data      (rd_data),
    .rd_slot_valid(rd_slot_valid),
    .rd_ptr_full  (rd_ptr_full),
    .next_rd_ptr  (next_rd_ptr),
    .dout         (dout),
    .rd_stale     (rd_stale)
  );

  // Fed the next pointers so count moves on the same edge as the pointers
  fifo_occupancy occupancy_i (
    .clk        (clk),
    .reset      (reset),
    .wr_ptr_full(next_wr_ptr),
    .rd_ptr_full(next_rd_ptr),
    .count      (count),
    .full       (full),
    .empty      (empty)
  );

  fifo_store_chk store_chk_i (
    .clk        (clk),
    .wr_en      (wr_en),
    .rd_en      (rd_en),
    .din        (din),
    .dout       (dout),
    .wr_ptr     (wr_ptr_full),
    .rd_ptr     (rd_ptr_full),
    .next_wr_ptr(next_wr_ptr),
    .next_rd_ptr(next_rd_ptr),
    .rd_data    (rd_data)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the tagged FIFO testbench with Verilator, runs it and checks the log

rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_tagged_fifo -o tb_tagged_fifo > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_tagged_fifo > sim.log 2>&1

grep -q -x -F '>>> PASS' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- sources.f
hdl/fifo_geom_pkg.sv
hdl/fifo_word_pkg.sv
hdl/fifo_write_port.sv
hdl/fifo_store.sv
hdl/fifo_read_port.sv
hdl/fifo_occupancy.sv
hdl/fifo_store_chk.sv
hdl/tagged_fifo.sv
testbench/tb_tagged_fifo.sv

//--- testbench/tb_tagged_fifo.sv
// Directed testbench for the tagged FIFO, checks against a queue and slot-record model
// Inputs change on the falling edge, outputs are sampled away from the rising edge
`timescale 1ns/1ps

module tb_tagged_fifo;

  logic                                  clk;
  logic                                  reset;
  logic                                  wr_en;
  logic                                  rd_en;
  logic [fifo_geom_pkg::data_width-1:0]  din;
  logic [fifo_geom_pkg::data_width-1:0]  dout;
  logic                                  rd_stale;
  logic [fifo_geom_pkg::count_width-1:0] count;
  logic                                  full;
  logic                                  empty;

  // Reference model: words in FIFO order plus what each slot last received
  logic [fifo_geom_pkg::data_width-1:0] fifo_q [$];
  logic [fifo_geom_pkg::data_width-1:0] slot_data [fifo_geom_pkg::depth];
  logic                                 slot_lap [fifo_geom_pkg::depth];
  bit                                   slot_written [fifo_geom_pkg::depth];
  logic [fifo_geom_pkg::ptr_width-1:0]  wr_ptr_m;
  logic [fifo_geom_pkg::ptr_width-1:0]  rd_ptr_m;
  logic [fifo_geom_pkg::data_width-1:0] hold_m;
  bit                                   hold_known;
  logic [31:0]                          lfsr_state;
  string                                test_name;

  tagged_fifo tagged_fifo_i (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (wr_en),
    .din     (din),
    .rd_en   (rd_en),
    .dout    (dout),
    .rd_stale(rd_stale),
    .count   (count),
    .full    (full),
    .empty   (empty)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [fifo_geom_pkg::data_width-1:0] random_word();
    logic [fifo_geom_pkg::data_width-1:0] word;
    word = '0;
    for (int i = 0; i < fifo_geom_pkg::data_width; i++) begin
      word = {word[fifo_geom_pkg::data_width-2:0], take_bit()};
    end
    return word;
  endfunction

  task automatic check_data(input string what,
                            input logic [fifo_geom_pkg::data_width-1:0] actual,
                            input logic [fifo_geom_pkg::data_width-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_count(input string what,
                             input logic [fifo_geom_pkg::count_width-1:0] actual,
                             input logic [fifo_geom_pkg::count_width-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_flag(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("ERR %s %s: expected %b, actual %b", test_name, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    wr_en = 1'b0;
    rd_en = 1'b0;
    din   = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    fifo_q.delete();
    for (int i = 0; i < fifo_geom_pkg::depth; i++) begin
      slot_written[i] = 1'b0;
    end
    wr_ptr_m   = '0;
    rd_ptr_m   = '0;
    hold_m     = '0;
    hold_known = 1'b1;
  endtask

  // Registered outputs reflect all strobes up to the last rising edge
  task automatic sample_registered();
    logic [fifo_geom_pkg::count_width-1:0] exp_count;
    @(negedge clk);
    exp_count = wr_ptr_m - rd_ptr_m;
    check_count("count", count, exp_count);
    check_flag("full", full, exp_count == fifo_geom_pkg::depth);
    check_flag("empty", empty, exp_count == 0);
  endtask

  task automatic drive_and_check(input logic wr, input logic rd);
    logic [fifo_geom_pkg::addr_width-1:0] slot;
    logic [fifo_geom_pkg::data_width-1:0] exp_dout;
    logic                                 stale;
    bit                                   known;
    wr_en = wr;
    rd_en = rd;
    din   = wr ? random_word() : '0;
    #1;
    if (rd) begin
      slot     = rd_ptr_m[fifo_geom_pkg::addr_width-1:0];
      stale    = !slot_written[slot] || slot_lap[slot] != rd_ptr_m[fifo_geom_pkg::addr_width];
      known    = slot_written[slot];
      exp_dout = slot_data[slot];
      // The oldest word is consumed, or lost when its slot was overrun
      if (fifo_q.size() > 0) begin
        if (!stale) begin
          exp_dout = fifo_q.pop_front();
        end else begin
          void'(fifo_q.pop_front());
        end
      end
      check_flag("rd_stale", rd_stale, stale);
      if (known) begin
        check_data("dout", dout, exp_dout);
      end
      hold_m     = exp_dout;
      hold_known = known;
      rd_ptr_m   = rd_ptr_m + 1'b1;
    end else begin
      check_flag("rd_stale idle", rd_stale, 1'b0);
      if (hold_known) begin
        check_data("dout hold", dout, hold_m);
      end
    end
    // Write goes in after the read, same-slot reads see the old word
    if (wr) begin
      slot               = wr_ptr_m[fifo_geom_pkg::addr_width-1:0];
      slot_data[slot]    = din;
      slot_lap[slot]     = wr_ptr_m[fifo_geom_pkg::addr_width];
      slot_written[slot] = 1'b1;
      fifo_q.push_back(din);
      wr_ptr_m = wr_ptr_m + 1'b1;
    end
  endtask

  task automatic run_cycle(input logic wr, input logic rd);
    sample_registered();
    drive_and_check(wr, rd);
  endtask

  // Reader is one slot past the writer and this word lands behind it
  task automatic write_behind_reader();
    run_cycle(1'b1, 1'b0);
    void'(fifo_q.pop_back());
  endtask

  task automatic drain_until_empty(input int max_cycles);
    int n;
    n = 0;
    sample_registered();
    while (!empty) begin
      if (n == max_cycles) begin
        $display("Timeout in %s: FIFO not empty after %0d reads", test_name, n);
        $display(">>> FAIL");
        $fatal(1, "drain timeout");
      end
      drive_and_check(1'b0, 1'b1);
      sample_registered();
      n++;
    end
    drive_and_check(1'b0, 1'b0);
  endtask

  task automatic test_fill_drain();
    test_name = "fill_drain";
    repeat (fifo_geom_pkg::depth) run_cycle(1'b1, 1'b0);
    sample_registered();
    check_flag("full after fill", full, 1'b1);
    drive_and_check(1'b0, 1'b0);
    drain_until_empty(fifo_geom_pkg::depth + 2);
    check_flag("empty after drain", empty, 1'b1);
  endtask

  // Random strobes that never overrun or underrun
  task automatic test_occupancy();
    logic [fifo_geom_pkg::count_width-1:0] occ;
    logic                                  wr;
    logic                                  rd;
    test_name = "occupancy";
    repeat (40) begin
      occ = wr_ptr_m - rd_ptr_m;
      wr  = take_bit();
      rd  = take_bit();
      if (occ == fifo_geom_pkg::depth) wr = 1'b0;
      if (occ == 0) rd = 1'b0;
      run_cycle(wr, rd);
    end
  endtask

  task automatic test_simultaneous();
    test_name = "simultaneous";
    drain_until_empty(fifo_geom_pkg::depth + 2);
    repeat (fifo_geom_pkg::depth / 2) run_cycle(1'b1, 1'b0);
    // Three laps so both pointers wrap more than once
    repeat (3 * fifo_geom_pkg::depth) begin
      run_cycle(1'b1, 1'b1);
      check_count("steady count", count, fifo_geom_pkg::count_width'(fifo_geom_pkg::depth / 2));
    end
  endtask

  task automatic test_hold();
    logic [fifo_geom_pkg::data_width-1:0] held;
    test_name = "hold";
    run_cycle(1'b0, 1'b1);
    held = hold_m;
    repeat (6) begin
      run_cycle(1'b1, 1'b0);
      check_data("dout while writing", dout, held);
    end
  endtask

  task automatic test_underrun();
    test_name = "underrun";
    // Slot 0 has not been written since reset
    run_cycle(1'b0, 1'b1);
    check_flag("stale on never-written slot", rd_stale, 1'b1);
    run_cycle(1'b0, 1'b0);
    check_flag("stale without read", rd_stale, 1'b0);
    write_behind_reader();
    repeat (fifo_geom_pkg::depth) run_cycle(1'b1, 1'b0);
    repeat (fifo_geom_pkg::depth) run_cycle(1'b0, 1'b1);
    // The next slot still holds the previous lap
    run_cycle(1'b0, 1'b1);
    check_flag("stale on earlier lap", rd_stale, 1'b1);
    write_behind_reader();
    run_cycle(1'b0, 1'b0);
  endtask

  task automatic test_overrun();
    test_name = "overrun";
    drain_until_empty(fifo_geom_pkg::depth + 2);
    repeat (fifo_geom_pkg::depth + 1) run_cycle(1'b1, 1'b0);
    sample_registered();
    check_count("count after overrun", count,
                fifo_geom_pkg::count_width'(fifo_geom_pkg::depth + 1));
    check_flag("full after overrun", full, 1'b0);
    drive_and_check(1'b0, 1'b1);
    check_flag("stale on overrun slot", rd_stale, 1'b1);
    repeat (fifo_geom_pkg::depth) run_cycle(1'b0, 1'b1);
    run_cycle(1'b0, 1'b0);
    check_flag("empty after overrun drain", empty, 1'b1);
  endtask

  initial begin
    reset      = 1'b1;
    wr_en      = 1'b0;
    rd_en      = 1'b0;
    din        = '0;
    lfsr_state = 32'd97346;
    test_name  = "reset";
    apply_reset();
    test_underrun();
    test_fill_drain();
    test_occupancy();
    test_simultaneous();
    test_hold();
    test_overrun();
    $display(">>> PASS");
    $finish;
  end

endmodule
